// ==== build.f ====
rtl/mmuPkg.sv
rtl/excPkg.sv
rtl/segmentMapper.sv
rtl/tlbArray.sv
rtl/tlbRegs.sv
rtl/dtlbStage.sv
rtl/dmmuTop.sv
verif/dmmuTb.sv

// ==== rtl/dmmuTop.sv ====
module dmmuTop #(
    parameter int tlbEntries = 16
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            reqValid,
    input  mmuPkg::memReqT  req,
    output logic            reqReady,
    output logic            respValid,
    output mmuPkg::memRespT resp,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  logic [31:0]     paddr,
    input  logic [31:0]     pwdata,
    output logic [31:0]     prdata,
    output logic            pready,
    output logic            pslverr
);

    localparam int indexWidth = $clog2(tlbEntries);

    logic                   tlbWrite;
    logic [indexWidth-1:0]  tlbWriteIndex;
    mmuPkg::tlbEntryT       tlbWriteEntry;
    logic [18:0]            searchVpn2;
    mmuPkg::lookupT         lookup;
    logic [31:0]            vaddr;
    mmuPkg::segKindT        segKind;
    logic [19:0]            unmappedPfn;

    tlbRegs #(
        .tlbEntries(tlbEntries)
    ) i_tlbRegs (
        .clk, .reset,
        .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
        .tlbWrite, .tlbWriteIndex, .tlbWriteEntry
    );

    tlbArray #(
        .tlbEntries(tlbEntries)
    ) i_tlbArray (
        .clk, .reset,
        .tlbWrite, .tlbWriteIndex, .tlbWriteEntry,
        .searchVpn2, .lookup
    );

    segmentMapper i_segmentMapper (
        .vaddr, .segKind, .unmappedPfn
    );

    // every tlbwi also flushes the translation buffer
    dtlbStage i_dtlbStage (
        .clk, .reset,
        .reqValid, .req, .reqReady,
        .flush(tlbWrite),
        .searchVpn2, .lookup,
        .vaddr, .segKind, .unmappedPfn,
        .respValid, .resp
    );

endmodule

// ==== rtl/dtlbStage.sv ====
module dtlbStage (
    input  logic            clk,
    input  logic            reset,
    input  logic            reqValid,
    input  mmuPkg::memReqT  req,
    output logic            reqReady,
    input  logic            flush,
    output logic [18:0]     searchVpn2,
    input  mmuPkg::lookupT  lookup,
    output logic [31:0]     vaddr,
    input  mmuPkg::segKindT segKind,
    input  logic [19:0]     unmappedPfn,
    output logic            respValid,
    output mmuPkg::memRespT resp
);

    typedef enum logic {
        idle,
        search
    } stateT;

    stateT            state;
    stateT            nextState;
    logic             holdValid;
    mmuPkg::memReqT   holdReq;
    logic             bufValid;
    logic [18:0]      bufVpn2;
    mmuPkg::lookupT   bufLookup;
    logic             isMapped;
    logic             isAccess;
    logic             bufHit;
    logic             miss;
    mmuPkg::pageInfoT page;
    excPkg::excCodeT  code;
    mmuPkg::memRespT  respNext;

    assign vaddr      = holdReq.vaddr;
    assign searchVpn2 = holdReq.vaddr[31:13];

    assign isMapped = segKind == mmuPkg::mapped;
    assign isAccess = holdReq.read || holdReq.store;
    assign bufHit   = bufValid && bufVpn2 == holdReq.vaddr[31:13];
    assign miss     = holdValid && isMapped && isAccess && !bufHit;
    assign reqReady = !miss;                // stall only on buffer miss

    always_ff @(posedge clk) begin
        if (reset) begin
            holdValid <= 1'b0;
        end else if (reqReady) begin
            holdValid <= reqValid;
        end
    end

    always_ff @(posedge clk) begin
        if (reqReady && reqValid) begin
            holdReq <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        case (state)
            idle:    nextState = miss ? search : idle;
            search:  nextState = idle;      // buffer refilled this cycle
            default: nextState = idle;
        endcase
    end

    // flush wins over a refill in the same cycle
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            bufValid <= 1'b0;
        end else if (state == search) begin
            bufValid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == search) begin
            bufVpn2   <= searchVpn2;
            bufLookup <= lookup;
        end
    end

    assign page = holdReq.vaddr[12] ? bufLookup.page1 : bufLookup.page0;   // odd/even

    always_comb begin
        if (!isMapped || !isAccess) begin
            code = excPkg::noEx;
        end else if (!bufLookup.found) begin
            code = holdReq.read ? excPkg::rdRefill : excPkg::wrRefill;
        end else if (!page.v) begin
            code = holdReq.read ? excPkg::rdInvalid : excPkg::wrInvalid;
        end else if (holdReq.store && !page.d) begin
            code = excPkg::modified;
        end else begin
            code = excPkg::noEx;
        end
    end

    always_comb begin
        respNext.paddr = {isMapped ? page.pfn : unmappedPfn, holdReq.vaddr[11:0]};
        case (segKind)
            mmuPkg::kseg1: respNext.uncache = 1'b1;
            mmuPkg::kseg0: respNext.uncache = 1'b0;
            default:       respNext.uncache = page.c != mmuPkg::cacheableAttr;
        endcase
        respNext.exc     = code != excPkg::noEx;
        respNext.excCode = code;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            respValid <= 1'b0;
        end else begin
            respValid <= holdValid && !miss;
        end
    end

    always_ff @(posedge clk) begin
        if (holdValid && !miss) begin
            resp <= respNext;
        end
    end

endmodule

// ==== rtl/excPkg.sv ====
package excPkg;

    typedef enum logic [4:0] {
        noEx      = 5'd0,
        modified  = 5'd1,
        rdRefill  = 5'd2,
        wrRefill  = 5'd3,
        rdInvalid = 5'd4,
        wrInvalid = 5'd5
    } excCodeT;

    // APB byte offsets of the CP0 stand-in registers
    localparam logic [31:0] regEntryHi  = 32'h00;
    localparam logic [31:0] regEntryLo0 = 32'h04;
    localparam logic [31:0] regEntryLo1 = 32'h08;
    localparam logic [31:0] regIndex    = 32'h0C;
    localparam logic [31:0] regCommand  = 32'h10;   // write performs tlbwi

endpackage

// ==== rtl/mmuPkg.sv ====
package mmuPkg;

    // attributes of one 4 KB page as held in EntryLo
    typedef struct packed {
        logic [19:0] pfn;
        logic [2:0]  c;         // cache attribute
        logic        d;         // dirty bit allows stores
        logic        v;
    } pageInfoT;

    // one joint TLB entry maps an even/odd page pair
    typedef struct packed {
        logic [18:0] vpn2;
        logic        entryValid;
        pageInfoT    page0;     // even page
        pageInfoT    page1;     // odd page
    } tlbEntryT;

    typedef struct packed {
        logic     found;
        pageInfoT page0;
        pageInfoT page1;
    } lookupT;

    typedef enum logic [1:0] {
        mapped = 2'd0,
        kseg0  = 2'd1,
        kseg1  = 2'd2
    } segKindT;

    typedef struct packed {
        logic [31:0] vaddr;
        logic        read;
        logic        store;
    } memReqT;

    typedef struct packed {
        logic [31:0] paddr;
        logic        uncache;
        logic        exc;
        logic [4:0]  excCode;
    } memRespT;

    localparam logic [2:0] cacheableAttr = 3'd3;   // cacheable noncoherent

endpackage

// ==== rtl/segmentMapper.sv ====
module segmentMapper (
    input  logic [31:0]     vaddr,
    output mmuPkg::segKindT segKind,
    output logic [19:0]     unmappedPfn
);

    logic [3:0] topNibble;

    assign topNibble = vaddr[31:28];

    always_comb begin
        case (topNibble)
            4'h8,
            4'h9: begin
                segKind = mmuPkg::kseg0;    // cached
            end
            4'hA,
            4'hB: begin
                segKind = mmuPkg::kseg1;    // uncached
            end
            default: begin
                segKind = mmuPkg::mapped;
            end
        endcase
    end

    // both unmapped segments alias the low 512 MB
    assign unmappedPfn = {3'b000, vaddr[28:12]};

endmodule

// ==== rtl/tlbArray.sv ====
module tlbArray #(
    parameter int tlbEntries = 16,
    localparam int indexWidth = $clog2(tlbEntries)
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   tlbWrite,
    input  logic [indexWidth-1:0]  tlbWriteIndex,
    input  mmuPkg::tlbEntryT       tlbWriteEntry,
    input  logic [18:0]            searchVpn2,
    output mmuPkg::lookupT         lookup
);

    mmuPkg::tlbEntryT        entries [tlbEntries];
    logic [tlbEntries-1:0]   entryValid;

    always_ff @(posedge clk) begin
        if (reset) begin
            entryValid <= '0;       // empty TLB
        end else if (tlbWrite) begin
            entryValid[tlbWriteIndex] <= tlbWriteEntry.entryValid;
        end
    end

    always_ff @(posedge clk) begin
        if (tlbWrite) begin
            entries[tlbWriteIndex] <= tlbWriteEntry;
        end
    end

    // fully associative match over all entries in parallel
    always_comb begin
        lookup = '0;
        for (int i = tlbEntries - 1; i >= 0; i--) begin
            if (entryValid[i] && entries[i].vpn2 == searchVpn2) begin
                lookup.found = 1'b1;
                lookup.page0 = entries[i].page0;    // lowest index wins
                lookup.page1 = entries[i].page1;
            end
        end
    end

endmodule

// ==== rtl/tlbRegs.sv ====
module tlbRegs #(
    parameter int tlbEntries = 16,
    localparam int indexWidth = $clog2(tlbEntries)
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [31:0]            paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   tlbWrite,
    output logic [indexWidth-1:0]  tlbWriteIndex,
    output mmuPkg::tlbEntryT       tlbWriteEntry
);

    logic [18:0]      hiVpn2;
    mmuPkg::pageInfoT lo0;
    mmuPkg::pageInfoT lo1;
    logic [indexWidth-1:0] index;
    logic             addrHit;
    logic             accessPhase;
    logic             wrEn;

    // MIPS EntryLo layout without the global bit
    function automatic mmuPkg::pageInfoT wordToPage(input logic [31:0] w);
        mmuPkg::pageInfoT p;
        p.pfn = w[25:6];
        p.c   = w[5:3];
        p.d   = w[2];
        p.v   = w[1];
        return p;
    endfunction

    function automatic logic [31:0] pageToWord(input mmuPkg::pageInfoT p);
        return {6'b0, p.pfn, p.c, p.d, p.v, 1'b0};
    endfunction

    always_comb begin
        case (paddr)
            excPkg::regEntryHi,
            excPkg::regEntryLo0,
            excPkg::regEntryLo1,
            excPkg::regIndex,
            excPkg::regCommand: addrHit = 1'b1;
            default:            addrHit = 1'b0;
        endcase
    end

    assign accessPhase = psel && penable;
    assign wrEn        = accessPhase && pwrite && addrHit;
    assign pready      = 1'b1;              // no wait states
    assign pslverr     = accessPhase && !addrHit;

    always_ff @(posedge clk) begin
        if (reset) begin
            hiVpn2 <= '0;
            lo0    <= '0;
            lo1    <= '0;
            index  <= '0;
        end else if (wrEn) begin
            case (paddr)
                excPkg::regEntryHi:  hiVpn2 <= pwdata[31:13];
                excPkg::regEntryLo0: lo0    <= wordToPage(pwdata);
                excPkg::regEntryLo1: lo1    <= wordToPage(pwdata);
                excPkg::regIndex:    index  <= pwdata[indexWidth-1:0];
                default: ;                  // command has no storage
            endcase
        end
    end

    always_comb begin
        case (paddr)
            excPkg::regEntryHi:  prdata = {hiVpn2, 13'b0};
            excPkg::regEntryLo0: prdata = pageToWord(lo0);
            excPkg::regEntryLo1: prdata = pageToWord(lo1);
            excPkg::regIndex:    prdata = {{(32 - indexWidth){1'b0}}, index};
            default:             prdata = '0;
        endcase
    end

    // tlbwi lands at the edge closing the access phase
    assign tlbWrite      = wrEn && paddr == excPkg::regCommand;
    assign tlbWriteIndex = index;
    assign tlbWriteEntry = '{vpn2: hiVpn2, entryValid: 1'b1, page0: lo0, page1: lo1};

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the data-side MMU testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 -f build.f --top-module dmmuTb -o dmmuSim

out=$(./obj_dir/dmmuSim)
echo "$out"

if echo "$out" | grep -qx "all tests passed"; then
    exit 0
else
    exit 1
fi

// ==== verif/dmmuTb.sv ====
module dmmuTb;

    localparam int respLimit = 20;
    localparam int maxCycles = 2000;        // 16 accesses and 31 APB transfers take under 200
    localparam logic [31:0] hiMask = 32'hFFFF_E000;
    localparam logic [31:0] loMask = 32'h03FF_FFFE;

    logic            clk;
    logic            reset;
    logic            reqValid;
    mmuPkg::memReqT  req;
    logic            reqReady;
    logic            respValid;
    mmuPkg::memRespT resp;
    logic            psel;
    logic            penable;
    logic            pwrite;
    logic [31:0]     paddr;
    logic [31:0]     pwdata;
    logic [31:0]     prdata;
    logic            pready;
    logic            pslverr;

    int     errorCount = 0;
    int     checkCount = 0;
    int     cycleCount = 0;
    integer seed = 8750;

    dmmuTop i_dut (
        .clk, .reset,
        .reqValid, .req, .reqReady, .respValid, .resp,
        .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        while (cycleCount < maxCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("run stopped after %0d cycles without finishing", cycleCount);
        $display("tests failed");
        $finish;
    end

    function automatic mmuPkg::memRespT makeResp(input logic [31:0] pa, input logic unc,
                                                 input excPkg::excCodeT code);
        mmuPkg::memRespT r;
        r.paddr   = pa;
        r.uncache = unc;
        r.exc     = code != excPkg::noEx;
        r.excCode = code;
        return r;
    endfunction

    // EntryLo word, MIPS layout
    function automatic logic [31:0] loWord(input logic [19:0] pfn, input logic [2:0] c,
                                           input logic d, input logic v);
        return {6'b0, pfn, c, d, v, 1'b0};
    endfunction

    task automatic randomPfn(output logic [19:0] pfn);
        logic [31:0] r;
        r = $random(seed);
        pfn = r[19:0];
    endtask

    task automatic checkResp(input string name, input mmuPkg::memRespT got,
                             input mmuPkg::memRespT exp, input logic cmpAddr);
        logic bad;
        checkCount++;
        if (cmpAddr) begin
            bad = got !== exp;
        end else begin
            bad = got.exc !== exp.exc || got.excCode !== exp.excCode;   // exception only
        end
        if (bad) begin
            errorCount++;
            $display("** Error %s resp: got paddr %h uncache %h exc %h excCode %h", name,
                     got.paddr, got.uncache, got.exc, got.excCode);
            $display("** Error %s resp: expected paddr %h uncache %h exc %h excCode %h", name,
                     exp.paddr, exp.uncache, exp.exc, exp.excCode);
        end
    endtask

    task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("** Error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("** Error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkLatency(input string name, input int got, input int exp);
        checkCount++;
        if (got != exp) begin
            errorCount++;
            $display("** Error %s latency: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic apbWrite(input logic [31:0] addr, input logic [31:0] data, input logic expErr);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #1;                                 // mid access phase
        checkBit("pready", pready, 1'b1);
        checkBit("pslverr", pslverr, expErr);
        @(negedge clk);                     // write lands on the edge before
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apbRead(input logic [31:0] addr, input logic expErr, output logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        #1;
        checkBit("pready", pready, 1'b1);
        checkBit("pslverr", pslverr, expErr);
        data = prdata;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic writeEntry(input logic [31:0] idx, input logic [31:0] hi,
                              input logic [31:0] lo0, input logic [31:0] lo1);
        apbWrite(excPkg::regEntryHi, hi, 1'b0);
        apbWrite(excPkg::regEntryLo0, lo0, 1'b0);
        apbWrite(excPkg::regEntryLo1, lo1, 1'b0);
        apbWrite(excPkg::regIndex, idx, 1'b0);
        apbWrite(excPkg::regCommand, 32'h0, 1'b0);  // tlbwi
    endtask

    // latency counts edges from acceptance to the response edge
    task automatic doRequest(input logic [31:0] va, input logic isStore,
                             output mmuPkg::memRespT r, output int lat);
        int stallCnt;
        @(negedge clk);
        reqValid = 1'b1;
        req      = '{vaddr: va, read: !isStore, store: isStore};
        stallCnt = 0;
        while (!reqReady && stallCnt < respLimit) begin
            @(negedge clk);
            stallCnt++;
        end
        if (!reqReady) begin
            errorCount++;
            $display("request to %h was never accepted", va);
        end
        @(posedge clk);
        @(negedge clk);
        reqValid = 1'b0;
        lat = 0;
        while (!respValid && lat < respLimit) begin
            @(negedge clk);
            lat++;
        end
        if (!respValid) begin
            errorCount++;
            $display("no response for the request to %h", va);
        end
        r = resp;
    endtask

    task automatic expectAccess(input string name, input logic [31:0] va, input logic isStore,
                                input mmuPkg::memRespT exp, input logic cmpAddr, input int expLat);
        mmuPkg::memRespT r;
        int lat;
        doRequest(va, isStore, r, lat);
        checkResp(name, r, exp, cmpAddr);
        checkLatency(name, lat, expLat);
    endtask

    task automatic testUnmapped();
        logic [31:0] va [4];
        va = '{32'h8123_4567, 32'hA765_4321, 32'h9ABC_DEF0, 32'hBFFF_FFFC};
        expectAccess("kseg0 read", va[0], 1'b0, makeResp(va[0] & 32'h1FFF_FFFF, 1'b0,
                     excPkg::noEx), 1'b1, 1);
        expectAccess("kseg1 read", va[1], 1'b0, makeResp(va[1] & 32'h1FFF_FFFF, 1'b1,
                     excPkg::noEx), 1'b1, 1);
        expectAccess("kseg0 store", va[2], 1'b1, makeResp(va[2] & 32'h1FFF_FFFF, 1'b0,
                     excPkg::noEx), 1'b1, 1);
        expectAccess("kseg1 store", va[3], 1'b1, makeResp(va[3] & 32'h1FFF_FFFF, 1'b1,
                     excPkg::noEx), 1'b1, 1);
    endtask

    task automatic testApbRegs();
        logic [31:0] rd;
        apbWrite(excPkg::regEntryHi, 32'h1234_5FFF, 1'b0);
        apbRead(excPkg::regEntryHi, 1'b0, rd);
        checkWord("EntryHi", rd, 32'h1234_5FFF & hiMask);
        apbWrite(excPkg::regEntryLo0, 32'hFFFF_FFFF, 1'b0);
        apbRead(excPkg::regEntryLo0, 1'b0, rd);
        checkWord("EntryLo0", rd, 32'hFFFF_FFFF & loMask);
        apbWrite(excPkg::regEntryLo1, 32'h5A5A_A5A5, 1'b0);
        apbRead(excPkg::regEntryLo1, 1'b0, rd);
        checkWord("EntryLo1", rd, 32'h5A5A_A5A5 & loMask);
        apbWrite(excPkg::regIndex, 32'hFFFF_FFFB, 1'b0);
        apbRead(excPkg::regIndex, 1'b0, rd);
        checkWord("Index", rd, 32'h0000_000B);    // 4 index bits for 16 entries
        apbRead(excPkg::regCommand, 1'b0, rd);
        checkWord("Command", rd, 32'h0);
        apbWrite(32'h14, 32'h0, 1'b1);
        apbRead(32'h14, 1'b1, rd);
    endtask

    task automatic testRefill();
        expectAccess("empty read", 32'h0040_1000, 1'b0, makeResp('0, 1'b0, excPkg::rdRefill),
                     1'b0, 3);
        expectAccess("empty store", 32'h0050_2000, 1'b1, makeResp('0, 1'b0, excPkg::wrRefill),
                     1'b0, 3);
    endtask

    task automatic testMapped();
        logic [19:0] pfn0;
        logic [19:0] pfn1;
        logic [31:0] base;
        base = 32'h1234_6000;
        randomPfn(pfn0);
        randomPfn(pfn1);
        writeEntry(32'd3, base, loWord(pfn0, 3'd3, 1'b1, 1'b1), loWord(pfn1, 3'd2, 1'b1, 1'b1));
        expectAccess("even read", base | 32'h0ABC, 1'b0, makeResp({pfn0, 12'hABC}, 1'b0,
                     excPkg::noEx), 1'b1, 3);
        expectAccess("odd read", base | 32'h1123, 1'b0, makeResp({pfn1, 12'h123}, 1'b1,
                     excPkg::noEx), 1'b1, 1);
        expectAccess("even store", base | 32'h0004, 1'b1, makeResp({pfn0, 12'h004}, 1'b0,
                     excPkg::noEx), 1'b1, 1);
    endtask

    task automatic testInvalidModified();
        logic [19:0] pfn0;
        logic [19:0] pfn1;
        logic [31:0] base;
        base = 32'h2468_0000;
        randomPfn(pfn0);
        randomPfn(pfn1);
        // even page invalid and odd page valid but clean
        writeEntry(32'd5, base, loWord(pfn0, 3'd3, 1'b1, 1'b0), loWord(pfn1, 3'd3, 1'b0, 1'b1));
        expectAccess("invalid read", base | 32'h0010, 1'b0, makeResp({pfn0, 12'h010}, 1'b0,
                     excPkg::rdInvalid), 1'b1, 3);
        expectAccess("invalid store", base | 32'h0020, 1'b1, makeResp({pfn0, 12'h020}, 1'b0,
                     excPkg::wrInvalid), 1'b1, 1);
        expectAccess("clean store", base | 32'h1030, 1'b1, makeResp({pfn1, 12'h030}, 1'b0,
                     excPkg::modified), 1'b1, 1);
        expectAccess("clean read", base | 32'h1040, 1'b0, makeResp({pfn1, 12'h040}, 1'b0,
                     excPkg::noEx), 1'b1, 1);
    endtask

    task automatic testFlush();
        logic [19:0] pfnOld;
        logic [19:0] pfnNew;
        logic [19:0] pfn1;
        logic [31:0] base;
        base = 32'h3000_2000;
        randomPfn(pfnOld);
        randomPfn(pfnNew);
        randomPfn(pfn1);
        if (pfnNew == pfnOld) begin
            pfnNew = ~pfnOld;
        end
        writeEntry(32'd7, base, loWord(pfnOld, 3'd3, 1'b1, 1'b1), loWord(pfn1, 3'd3, 1'b1, 1'b1));
        expectAccess("before rewrite", base | 32'h0010, 1'b0, makeResp({pfnOld, 12'h010}, 1'b0,
                     excPkg::noEx), 1'b1, 3);
        expectAccess("buffered", base | 32'h0014, 1'b0, makeResp({pfnOld, 12'h014}, 1'b0,
                     excPkg::noEx), 1'b1, 1);
        writeEntry(32'd7, base, loWord(pfnNew, 3'd3, 1'b1, 1'b1), loWord(pfn1, 3'd3, 1'b1, 1'b1));
        expectAccess("after rewrite", base | 32'h0018, 1'b0, makeResp({pfnNew, 12'h018}, 1'b0,
                     excPkg::noEx), 1'b1, 3);
    endtask

    initial begin
        reset    = 1'b1;
        reqValid = 1'b0;
        req      = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        testUnmapped();
        testApbRegs();
        testRefill();
        testMapped();
        testInvalidModified();
        testFlush();

        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
